/* common/fabric_config.svh */
// Fabric widths, FIFO depth and address map. Windows must be word aligned and must not overlap
`ifndef FABRIC_CONFIG_SVH
`define FABRIC_CONFIG_SVH

// --------------------------------------------------
// Bus widths
// --------------------------------------------------
`define FABRIC_ADDR_W 32
`define FABRIC_DATA_W 32

// Entries per FIFO, also the initial credit count of each sender
`define FABRIC_FIFO_DEPTH 4

// --------------------------------------------------
// Address map
// --------------------------------------------------
`define ROM_BASE  (32'h0000_1000)
`define ROM_WORDS 16

`define SRAM_BASE  (32'h8000_0000)
`define SRAM_WORDS 64

// Upper half of every boot ROM word
`define ROM_SIG (16'hB007)

`endif

/* common/fabric_pkg.sv */
// Shared fabric types and ROM contents, single-word accesses only with at most 16 index bits
`include "fabric_config.svh"

package fabric_pkg;

  localparam int unsigned ADDR_W     = `FABRIC_ADDR_W;
  localparam int unsigned DATA_W     = `FABRIC_DATA_W;
  localparam int unsigned BE_W       = DATA_W / 8;
  localparam int unsigned ROM_IDX_W  = $clog2(`ROM_WORDS);
  localparam int unsigned SRAM_IDX_W = $clog2(`SRAM_WORDS);
  // Word index wide enough for the larger region
  localparam int unsigned IDX_W      = (SRAM_IDX_W > ROM_IDX_W) ? SRAM_IDX_W : ROM_IDX_W;

  typedef enum logic [1:0] {
    TGT_ROM  = 2'd0,
    TGT_SRAM = 2'd1,
    TGT_ERR  = 2'd2
  } target_e;

  // Same codes as an AXI response
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } resp_e;

  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;
  } fabric_req_t;

  typedef struct packed {
    fabric_req_t      req;
    target_e          target;
    logic [IDX_W-1:0] index;
  } routed_req_t;

  typedef struct packed {
    resp_e             resp;
    logic [DATA_W-1:0] rdata;
  } fabric_resp_t;

  // Boot ROM word at a given index
  function automatic logic [DATA_W-1:0] rom_word(input logic [IDX_W-1:0] idx);
    logic [15:0] low;
    low = 16'(idx);
    return {`ROM_SIG, low};
  endfunction

endpackage

/* hw/req_router.sv */
// Address decoder and request producer. Low two address bits are ignored, accesses are whole words
`timescale 1ns/100ps
`include "fabric_config.svh"

module req_router import fabric_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  fabric_req_t req_i,
  input  logic        req_valid_i,
  output logic        req_ready_o,
  output logic        push_o,
  output routed_req_t push_data_o,
  input  logic        credit_i
);

  localparam int unsigned DEPTH  = `FABRIC_FIFO_DEPTH;
  localparam int unsigned CRED_W = $clog2(DEPTH + 1);

  localparam logic [ADDR_W-1:0] ROM_LO  = `ROM_BASE;
  localparam logic [ADDR_W-1:0] ROM_HI  = `ROM_BASE + 4 * `ROM_WORDS;
  localparam logic [ADDR_W-1:0] SRAM_LO = `SRAM_BASE;
  localparam logic [ADDR_W-1:0] SRAM_HI = `SRAM_BASE + 4 * `SRAM_WORDS;

  logic [CRED_W-1:0] credit_q;
  logic [CRED_W-1:0] credit_d;
  logic              accept;
  target_e           target;
  logic [ADDR_W-1:0] offset;
  routed_req_t       routed;
  logic              push_q;
  routed_req_t       push_data_q;

  // Ready as long as a FIFO slot is guaranteed
  assign req_ready_o = (credit_q != '0);
  assign accept      = req_valid_i & req_ready_o;

  // --------------------------------------------------
  // Address decode
  // --------------------------------------------------
  always_comb begin
    target = TGT_ERR;
    offset = '0;
    if (req_i.addr >= ROM_LO && req_i.addr < ROM_HI) begin
      target = TGT_ROM;
      offset = req_i.addr - ROM_LO;
    end else if (req_i.addr >= SRAM_LO && req_i.addr < SRAM_HI) begin
      target = TGT_SRAM;
      offset = req_i.addr - SRAM_LO;
    end
  end

  assign routed.req    = req_i;
  assign routed.target = target;
  assign routed.index  = offset[IDX_W+1:2];

  // --------------------------------------------------
  // Credits
  // --------------------------------------------------
  // Credit is spent at acceptance, the push follows one cycle later
  always_comb begin
    credit_d = credit_q;
    if (accept) begin
      credit_d = credit_d - 1'b1;
    end
    if (credit_i) begin
      credit_d = credit_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= CRED_W'(DEPTH);
      push_q   <= 1'b0;
    end else begin
      credit_q <= credit_d;
      push_q   <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      push_data_q <= routed;
    end
  end

  assign push_o      = push_q;
  assign push_data_o = push_data_q;

endmodule

/* hw/credit_fifo.sv */
// Credit-managed FIFO. A push while full corrupts the contents, so the sender must honour its credits
`timescale 1ns/100ps
`include "fabric_config.svh"

module credit_fifo #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = `FABRIC_FIFO_DEPTH
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  payload_t push_data_i,
  input  logic     pop_i,
  output payload_t pop_data_o,
  output logic     valid_o,
  output logic     credit_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             pop_en;

  // Wraps at DEPTH, which need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign valid_o    = (count_q != '0);
  assign pop_en     = pop_i & valid_o;
  assign pop_data_o = mem_q[rd_ptr_q];

  // One credit per entry that leaves, in the cycle it leaves
  assign credit_o = pop_en;

  // --------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_en) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({push_i, pop_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

/* mem_target/mem_target.sv */
// Boot ROM, byte-enabled SRAM and error target behind one request port, one access per cycle
`timescale 1ns/100ps
`include "fabric_config.svh"

module mem_target import fabric_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  routed_req_t  req_data_i,
  input  logic         req_valid_i,
  output logic         req_pop_o,
  output logic         resp_push_o,
  output fabric_resp_t resp_data_o,
  input  logic         resp_credit_i
);

  localparam int unsigned DEPTH  = `FABRIC_FIFO_DEPTH;
  localparam int unsigned CRED_W = $clog2(DEPTH + 1);

  logic [DATA_W-1:0]     sram_q [`SRAM_WORDS];
  logic [DATA_W-1:0]     rom [`ROM_WORDS];
  logic [CRED_W-1:0]     credit_q;
  logic [CRED_W-1:0]     credit_d;
  logic                  pop;
  fabric_req_t           req;
  logic [SRAM_IDX_W-1:0] sram_idx;
  logic [ROM_IDX_W-1:0]  rom_idx;
  logic                  sram_we;
  fabric_resp_t          resp_d;
  fabric_resp_t          resp_q;
  logic                  push_q;

  // --------------------------------------------------
  // Boot ROM contents
  // --------------------------------------------------
  for (genvar i = 0; i < `ROM_WORDS; i++) begin : g_rom
    assign rom[i] = rom_word(IDX_W'(i));
  end

  // Pop only when the response has a guaranteed slot
  assign pop       = req_valid_i & (credit_q != '0);
  assign req_pop_o = pop;

  assign req      = req_data_i.req;
  assign sram_idx = req_data_i.index[SRAM_IDX_W-1:0];
  assign rom_idx  = req_data_i.index[ROM_IDX_W-1:0];
  assign sram_we  = pop & req.write & (req_data_i.target == TGT_SRAM);

  // --------------------------------------------------
  // Response selection
  // --------------------------------------------------
  always_comb begin
    resp_d.resp  = RESP_DECERR;
    resp_d.rdata = '0;
    case (req_data_i.target)
      TGT_SRAM: begin
        resp_d.resp = RESP_OKAY;
        if (!req.write) begin
          resp_d.rdata = sram_q[sram_idx];
        end
      end
      TGT_ROM: begin
        // Read only, writes are refused
        if (req.write) begin
          resp_d.resp = RESP_SLVERR;
        end else begin
          resp_d.resp  = RESP_OKAY;
          resp_d.rdata = rom[rom_idx];
        end
      end
      default: begin
        resp_d.resp  = RESP_DECERR;
        resp_d.rdata = '0;
      end
    endcase
  end

  // Response credits
  always_comb begin
    credit_d = credit_q;
    if (pop) begin
      credit_d = credit_d - 1'b1;
    end
    if (resp_credit_i) begin
      credit_d = credit_d + 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= CRED_W'(DEPTH);
      push_q   <= 1'b0;
    end else begin
      credit_q <= credit_d;
      push_q   <= pop;
    end
  end

  // Registered response, pushed the cycle after the pop
  always_ff @(posedge clk_i) begin
    if (pop) begin
      resp_q <= resp_d;
    end
  end

  // --------------------------------------------------
  // SRAM with byte lanes
  // --------------------------------------------------
  // Zeroed by reset so unwritten words read back as zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < `SRAM_WORDS; w++) begin
        sram_q[w] <= '0;
      end
    end else if (sram_we) begin
      for (int b = 0; b < BE_W; b++) begin
        if (req.be[b]) begin
          sram_q[sram_idx][8*b +: 8] <= req.wdata[8*b +: 8];
        end
      end
    end
  end

  assign resp_push_o = push_q;
  assign resp_data_o = resp_q;

endmodule

/* hw/soc_fabric_top.sv */
// Fabric top level for a single requester, responses return in request order
`timescale 1ns/100ps
`include "fabric_config.svh"

module soc_fabric_top import fabric_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  fabric_req_t  req_i,
  input  logic         req_valid_i,
  output logic         req_ready_o,
  output fabric_resp_t resp_o,
  output logic         resp_valid_o,
  input  logic         resp_ready_i
);

  // Request hop
  logic         req_push;
  routed_req_t  req_push_data;
  logic         req_credit;
  routed_req_t  req_head;
  logic         req_head_valid;
  logic         req_pop;

  // Response hop
  logic         resp_push;
  fabric_resp_t resp_push_data;
  logic         resp_credit;

  req_router u_req_router (
    .clk_i       ( clk_i         ),
    .rst_ni      ( rst_ni        ),
    .req_i       ( req_i         ),
    .req_valid_i ( req_valid_i   ),
    .req_ready_o ( req_ready_o   ),
    .push_o      ( req_push      ),
    .push_data_o ( req_push_data ),
    .credit_i    ( req_credit    )
  );

  credit_fifo #(
    .payload_t ( routed_req_t       ),
    .DEPTH     ( `FABRIC_FIFO_DEPTH )
  ) u_req_fifo (
    .clk_i       ( clk_i          ),
    .rst_ni      ( rst_ni         ),
    .push_i      ( req_push       ),
    .push_data_i ( req_push_data  ),
    .pop_i       ( req_pop        ),
    .pop_data_o  ( req_head       ),
    .valid_o     ( req_head_valid ),
    .credit_o    ( req_credit     )
  );

  mem_target u_mem_target (
    .clk_i         ( clk_i          ),
    .rst_ni        ( rst_ni         ),
    .req_data_i    ( req_head       ),
    .req_valid_i   ( req_head_valid ),
    .req_pop_o     ( req_pop        ),
    .resp_push_o   ( resp_push      ),
    .resp_data_o   ( resp_push_data ),
    .resp_credit_i ( resp_credit    )
  );

  credit_fifo #(
    .payload_t ( fabric_resp_t      ),
    .DEPTH     ( `FABRIC_FIFO_DEPTH )
  ) u_resp_fifo (
    .clk_i       ( clk_i          ),
    .rst_ni      ( rst_ni         ),
    .push_i      ( resp_push      ),
    .push_data_i ( resp_push_data ),
    .pop_i       ( resp_ready_i   ),
    .pop_data_o  ( resp_o         ),
    .valid_o     ( resp_valid_o   ),
    .credit_o    ( resp_credit    )
  );

endmodule

/* verif/fabric_asserts.sv */
// Bound into soc_fabric_top, expects instances u_req_router and u_req_fifo with push_q and count_q
`timescale 1ns/100ps
`include "fabric_config.svh"

module fabric_asserts import fabric_pkg::*; (
  input logic         clk_i,
  input logic         rst_ni,
  input logic         req_ready_i,
  input logic         credit_zero_i,
  input fabric_resp_t resp_i,
  input logic         resp_valid_i,
  input logic         resp_ready_i
);

  int fail_cnt = 0;

  // Router must refuse requests once every request FIFO slot is committed
  ready_needs_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_zero_i |-> !req_ready_i)
  else begin
    fail_cnt++;
    $error("req_ready_o high while the router holds no credit");
  end

  // A stalled response keeps its value until taken
  resp_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_i))
  else begin
    fail_cnt++;
    $error("resp_o changed or dropped while stalled");
  end

  idle_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |-> !resp_valid_i)
  else begin
    fail_cnt++;
    $error("resp_valid_o high in the cycle after reset release");
  end

endmodule

// Credits are gone once the FIFO entries plus the pending push fill the FIFO
bind soc_fabric_top fabric_asserts u_fabric_asserts (
  .clk_i         ( clk_i                                       ),
  .rst_ni        ( rst_ni                                      ),
  .req_ready_i   ( req_ready_o                                 ),
  .credit_zero_i ( (u_req_fifo.count_q + u_req_router.push_q)
                   == `FABRIC_FIFO_DEPTH                       ),
  .resp_i        ( resp_o                                      ),
  .resp_valid_i  ( resp_valid_o                                ),
  .resp_ready_i  ( resp_ready_i                                )
);

/* verif/fabric_checker.sv */
// Expects responses in file order, reads verif/fabric_input.txt relative to the project root
`timescale 1ns/100ps
`include "fabric_config.svh"

module fabric_checker import fabric_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  fabric_resp_t resp_i,
  input  logic         resp_valid_i,
  input  logic         resp_ready_i,
  input  logic         report_i,
  output int           checked_o,
  output int           errors_o
);

  logic                      exp_write [$];
  logic [`FABRIC_ADDR_W-1:0] exp_addr [$];
  logic [1:0]                exp_resp [$];
  logic [`FABRIC_DATA_W-1:0] exp_rdata [$];
  int                        checked_cnt = 0;
  int                        error_cnt = 0;
  int                        pass_cnt = 0;
  logic                      reported = 1'b0;

  assign checked_o = checked_cnt;
  assign errors_o  = error_cnt;

  // --------------------------------------------------
  // Expected values, one entry per file line
  // --------------------------------------------------
  initial begin : load_expected
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] w, a, be, wd, rs, rd;
    fd = $fopen("verif/fabric_input.txt", "r");
    if (fd == 0) begin
      $display("Checker could not open verif/fabric_input.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) > 0) begin
          cnt = $sscanf(line, "%h %h %h %h %h %h", w, a, be, wd, rs, rd);
          if (cnt == 6) begin
            exp_write.push_back(w[0]);
            exp_addr.push_back(a);
            exp_resp.push_back(rs[1:0]);
            exp_rdata.push_back(rd);
          end
        end
      end
      $fclose(fd);
    end
  end

  // Compare every response taken at the output
  always @(posedge clk_i) begin : compare
    logic ok;
    if (rst_ni && resp_valid_i && resp_ready_i) begin
      if (exp_resp.size() == 0) begin
        $display("At %0t a response arrived with no request outstanding", $time);
        error_cnt++;
      end else begin
        ok = 1'b1;
        if (resp_i.resp !== exp_resp[0]) begin
          $display("MISMATCH at %0t: resp_o.resp expected %0d got %0d",
                   $time, exp_resp[0], resp_i.resp);
          ok = 1'b0;
        end
        if (resp_i.rdata !== exp_rdata[0]) begin
          $display("MISMATCH at %0t: resp_o.rdata expected %h got %h",
                   $time, exp_rdata[0], resp_i.rdata);
          ok = 1'b0;
        end
        $display("test %0d %s %h: %s", checked_cnt, exp_write[0] ? "write" : "read",
                 exp_addr[0], ok ? "ok" : "failed");
        if (ok) begin
          pass_cnt++;
        end else begin
          error_cnt++;
        end
        checked_cnt++;
        void'(exp_write.pop_front());
        void'(exp_addr.pop_front());
        void'(exp_resp.pop_front());
        void'(exp_rdata.pop_front());
      end
    end
  end

  always @(posedge clk_i) begin
    if (report_i && !reported) begin
      $display("Summary: %0d responses checked, %0d passed, %0d failed, %0d never arrived",
               checked_cnt, pass_cnt, error_cnt, exp_resp.size());
      reported = 1'b1;
    end
  end

endmodule

/* verif/tb_soc_fabric.sv */
// Run from the project root so verif/fabric_input.txt is found, requests are issued back to back
`timescale 1ns/100ps

module tb_soc_fabric import fabric_pkg::*; ();

  localparam int CLK_PERIOD      = 20;
  localparam int RESET_CYCLES    = 5;
  localparam int CYCLES_PER_TEST = 40;
  // Fixed output stall that forces the credits to run out
  localparam int HOLD_START      = 10;
  localparam int HOLD_END        = 26;

  logic         clk = 1'b0;
  logic         rst_n = 1'b0;
  fabric_req_t  req = '0;
  logic         req_valid = 1'b0;
  logic         req_ready;
  fabric_resp_t resp;
  logic         resp_valid;
  logic         resp_ready = 1'b1;
  logic         report = 1'b0;
  int           checked_cnt;
  int           check_errors;
  fabric_req_t  tests [$];
  int           n_tests = 0;
  logic         loaded = 1'b0;
  int           tb_errors = 0;
  int           ready_low_cnt = 0;
  int           cycle_cnt = 0;
  logic [31:0]  lfsr_q = 32'h68d7_817e;

  always #(CLK_PERIOD / 2) clk = ~clk;

  soc_fabric_top u_soc_fabric_top (
    .clk_i        ( clk        ),
    .rst_ni       ( rst_n      ),
    .req_i        ( req        ),
    .req_valid_i  ( req_valid  ),
    .req_ready_o  ( req_ready  ),
    .resp_o       ( resp       ),
    .resp_valid_o ( resp_valid ),
    .resp_ready_i ( resp_ready )
  );

  fabric_checker u_checker (
    .clk_i        ( clk          ),
    .rst_ni       ( rst_n        ),
    .resp_i       ( resp         ),
    .resp_valid_i ( resp_valid   ),
    .resp_ready_i ( resp_ready   ),
    .report_i     ( report       ),
    .checked_o    ( checked_cnt  ),
    .errors_o     ( check_errors )
  );

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic load_tests();
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] w, a, be, wd, rs, rd;
    fabric_req_t r;
    fd = $fopen("verif/fabric_input.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) > 0) begin
          cnt = $sscanf(line, "%h %h %h %h %h %h", w, a, be, wd, rs, rd);
          if (cnt == 6) begin
            r.write = w[0];
            r.addr  = a;
            r.be    = be[BE_W-1:0];
            r.wdata = wd;
            tests.push_back(r);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // Holds the request until an edge sees req_ready_o high
  task automatic drive_request(input fabric_req_t r, output int waits);
    waits = 0;
    req       <= r;
    req_valid <= 1'b1;
    do begin
      @(posedge clk);
      waits++;
    end while (!req_ready);
  endtask

  // --------------------------------------------------
  // Output stalls
  // --------------------------------------------------
  always @(posedge clk) begin : stall_gen
    logic b0;
    logic b1;
    logic hold;
    if (rst_n) begin
      b0 = lfsr_q[0];
      lfsr_q = lfsr_step(lfsr_q);
      b1 = lfsr_q[0];
      lfsr_q = lfsr_step(lfsr_q);
      hold = (cycle_cnt >= HOLD_START) && (cycle_cnt < HOLD_END);
      resp_ready <= !(b0 && b1) && !hold;
      cycle_cnt  <= cycle_cnt + 1;
    end
  end

  always @(posedge clk) begin
    if (rst_n && req_valid && !req_ready) begin
      ready_low_cnt <= ready_low_cnt + 1;
    end
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin : main_seq
    int waits;
    load_tests();
    n_tests = tests.size();
    loaded  = 1'b1;
    if (n_tests == 0) begin
      $display("No tests could be read from verif/fabric_input.txt");
      $display("SOME TESTS FAILED");
      $finish;
    end else begin
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      if (resp_valid) begin
        $display("resp_valid_o was high right after reset");
        tb_errors++;
      end
      for (int i = 0; i < n_tests; i++) begin
        drive_request(tests[i], waits);
        if (i == 0 && waits != 1) begin
          $display("First request after reset waited %0d cycles for acceptance", waits);
          tb_errors++;
        end
      end
      req_valid <= 1'b0;
      wait (checked_cnt == n_tests);
      // Leave room for any surplus response to show up
      repeat (10) @(posedge clk);
      if (ready_low_cnt == 0) begin
        $display("req_ready_o never dropped during the burst");
        tb_errors++;
      end
      report <= 1'b1;
      repeat (2) @(posedge clk);
      if (tb_errors == 0 && check_errors == 0 &&
          u_soc_fabric_top.u_fabric_asserts.fail_cnt == 0) begin
        $display("ALL TESTS PASSED");
      end else begin
        $display("SOME TESTS FAILED");
      end
      $finish;
    end
  end

  initial begin : watchdog
    wait (loaded);
    #((n_tests * CYCLES_PER_TEST + RESET_CYCLES) * CLK_PERIOD);
    $display("Timeout: only %0d of %0d responses arrived", checked_cnt, n_tests);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* soc_fabric.f */
+incdir+common
common/fabric_pkg.sv
hw/req_router.sv
hw/credit_fifo.sv
mem_target/mem_target.sv
hw/soc_fabric_top.sv
verif/fabric_asserts.sv
verif/fabric_checker.sv
verif/tb_soc_fabric.sv

/* Bender.yml */
package:
  name: soc_fabric

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/fabric_pkg.sv
      - hw/req_router.sv
      - hw/credit_fifo.sv
      - mem_target/mem_target.sv
      - hw/soc_fabric_top.sv
      - target: test
        files:
          - verif/fabric_asserts.sv
          - verif/fabric_checker.sv
          - verif/tb_soc_fabric.sv

/* verif/fabric_input.txt */
# Columns, all hex: write addr be wdata expected_resp expected_rdata
# Response codes: 0 OKAY, 2 SLVERR, 3 DECERR
0 80000010 f 00000000 0 00000000
1 80000000 f deadbeef 0 00000000
0 80000000 f 00000000 0 deadbeef
1 80000004 3 12345678 0 00000000
0 80000004 f 00000000 0 00005678
1 80000000 4 aabbccdd 0 00000000
0 80000000 f 00000000 0 debbbeef
0 00001000 f 00000000 0 b0070000
0 00001014 f 00000000 0 b0070005
0 0000103c f 00000000 0 b007000f
1 00001014 f ffffffff 2 00000000
0 00001014 f 00000000 0 b0070005
0 00000ffc f 00000000 3 00000000
1 00001040 f 11111111 3 00000000
0 80000100 f 00000000 3 00000000
1 40000000 f 22222222 3 00000000
1 800000fc f 0badf00d 0 00000000
0 800000fc f 00000000 0 0badf00d
1 80000040 f 00000040 0 00000000
1 80000044 f 00000044 0 00000000
1 80000048 f 00000048 0 00000000
0 80000040 f 00000000 0 00000040
0 80000044 f 00000000 0 00000044
0 80000048 f 00000000 0 00000048
0 00001020 f 00000000 0 b0070008
1 80000048 8 99000000 0 00000000
0 80000048 f 00000000 0 99000048
0 80000010 f 00000000 0 00000000
0 fffffffc f 00000000 3 00000000
0 80000004 f 00000000 0 00005678
